/* issue_pkg.sv */
`default_nettype none

package issue_pkg;

    localparam int XLEN        = 32;
    localparam int ISSUE_WIDTH = 2;
    localparam int NUM_REGS    = 32;
    localparam int RF_PORTS    = 2 * ISSUE_WIDTH;
    // ex, mem and wb bundles for every lane
    localparam int FWD_SRCS    = 3 * ISSUE_WIDTH;
    localparam int DMEM_WORDS  = 64;

    typedef logic [XLEN-1:0]               word_t;
    typedef logic [$clog2(NUM_REGS)-1:0]   reg_addr_t;
    typedef logic [$clog2(DMEM_WORDS)-1:0] mem_addr_t;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        ADDI = 4'd7,
        LW   = 4'd8,
        SW   = 4'd9
    } alu_op_t;

    // one decoded slot as offered by the decoder
    typedef struct packed {
        logic      valid;
        alu_op_t   op;
        reg_addr_t rs1;
        logic      rs1_en;
        reg_addr_t rs2;
        logic      rs2_en;
        reg_addr_t rd;
        logic      rd_en;
        word_t     imm;
    } dec_op_t;

    // operands already resolved, held in the ex register
    typedef struct packed {
        logic      valid;
        alu_op_t   op;
        reg_addr_t rd;
        logic      rd_en;
        word_t     src1;
        word_t     src2;
        word_t     imm;
    } issued_op_t;

endpackage

`default_nettype wire

/* fwd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fwd_if;

    logic                 we;
    issue_pkg::reg_addr_t addr;
    issue_pkg::word_t     data;
    // data not ready yet, ex stage only
    logic                 is_load;

    modport source (
        output we,
        output addr,
        output data,
        output is_load
    );

    modport sink (
        input we,
        input addr,
        input data,
        input is_load
    );

endinterface

`default_nettype wire

/* regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire                                                    clk,
    input  wire                                                    rst_i,
    input  wire issue_pkg::reg_addr_t [issue_pkg::RF_PORTS-1:0]    raddr_i,
    output issue_pkg::word_t          [issue_pkg::RF_PORTS-1:0]    rdata_o,
    input  wire                       [issue_pkg::ISSUE_WIDTH-1:0] we_i,
    input  wire issue_pkg::reg_addr_t [issue_pkg::ISSUE_WIDTH-1:0] waddr_i,
    input  wire issue_pkg::word_t     [issue_pkg::ISSUE_WIDTH-1:0] wdata_i
);

    issue_pkg::word_t regs [issue_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < issue_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // higher lane written last, younger op wins
            for (int w = 0; w < issue_pkg::ISSUE_WIDTH; w++) begin
                if (we_i[w] && waddr_i[w] != '0) begin
                    regs[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < issue_pkg::RF_PORTS; r++) begin
            if (raddr_i[r] == '0) begin
                rdata_o[r] = '0;
            end else begin
                rdata_o[r] = regs[raddr_i[r]];
            end
        end
    end

endmodule

`default_nettype wire

/* dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch (
    input  wire                                                     clk,
    input  wire                                                     rst_i,
    input  wire                                                     flush_i,
    input  wire issue_pkg::dec_op_t    [issue_pkg::ISSUE_WIDTH-1:0] slot_i,
    output issue_pkg::reg_addr_t       [issue_pkg::RF_PORTS-1:0]    rf_addr_o,
    input  wire issue_pkg::word_t      [issue_pkg::RF_PORTS-1:0]    rf_data_i,
    fwd_if.sink                                                     ex0,
    fwd_if.sink                                                     ex1,
    fwd_if.sink                                                     mem0,
    fwd_if.sink                                                     mem1,
    fwd_if.sink                                                     wb0,
    fwd_if.sink                                                     wb1,
    output logic                       [issue_pkg::ISSUE_WIDTH-1:0] accept_o,
    output logic                                                    stall_o,
    output issue_pkg::issued_op_t      [issue_pkg::ISSUE_WIDTH-1:0] ex_op_o
);

    issue_pkg::reg_addr_t [issue_pkg::RF_PORTS-1:0]    src_addr;
    logic                 [issue_pkg::RF_PORTS-1:0]    src_en;
    logic                 [issue_pkg::RF_PORTS-1:0]    src_live;
    issue_pkg::word_t     [issue_pkg::RF_PORTS-1:0]    operand;
    logic                 [issue_pkg::FWD_SRCS-1:0]    f_we;
    issue_pkg::reg_addr_t [issue_pkg::FWD_SRCS-1:0]    f_addr;
    issue_pkg::word_t     [issue_pkg::FWD_SRCS-1:0]    f_data;
    logic                 [issue_pkg::ISSUE_WIDTH-1:0] ex_load;
    issue_pkg::reg_addr_t [issue_pkg::ISSUE_WIDTH-1:0] ex_load_rd;
    logic                 [issue_pkg::ISSUE_WIDTH-1:0] slot_mem;
    issue_pkg::issued_op_t [issue_pkg::ISSUE_WIDTH-1:0] cand;
    logic                 raw_pair;
    logic                 dual_ok;
    logic                 can_issue;

    // port order is slot0 rs1, slot0 rs2, slot1 rs1, slot1 rs2
    assign src_addr  = {slot_i[1].rs2, slot_i[1].rs1, slot_i[0].rs2, slot_i[0].rs1};
    assign src_en    = {slot_i[1].rs2_en, slot_i[1].rs1_en, slot_i[0].rs2_en, slot_i[0].rs1_en};
    assign src_live  = src_en & {{2{slot_i[1].valid}}, {2{slot_i[0].valid}}};
    assign rf_addr_o = src_addr;

    // lowest index is lowest priority: wb, then mem, then ex
    assign f_we   = {ex1.we, ex0.we, mem1.we, mem0.we, wb1.we, wb0.we};
    assign f_addr = {ex1.addr, ex0.addr, mem1.addr, mem0.addr, wb1.addr, wb0.addr};
    assign f_data = {ex1.data, ex0.data, mem1.data, mem0.data, wb1.data, wb0.data};

    always_comb begin
        for (int r = 0; r < issue_pkg::RF_PORTS; r++) begin
            operand[r] = rf_data_i[r];
            for (int f = 0; f < issue_pkg::FWD_SRCS; f++) begin
                if (f_we[f] && f_addr[f] == src_addr[r]) begin
                    operand[r] = f_data[f];
                end
            end
            if (src_addr[r] == '0) begin
                operand[r] = '0;
            end
            if (!src_en[r]) begin
                operand[r] = slot_i[r / 2].imm;
            end
        end
    end

    // load-use hazard against either ex lane
    assign ex_load    = {ex1.is_load && ex1.we, ex0.is_load && ex0.we};
    assign ex_load_rd = {ex1.addr, ex0.addr};

    always_comb begin
        stall_o = 1'b0;
        for (int r = 0; r < issue_pkg::RF_PORTS; r++) begin
            for (int l = 0; l < issue_pkg::ISSUE_WIDTH; l++) begin
                if (src_live[r] && src_addr[r] != '0 && ex_load[l] &&
                    ex_load_rd[l] == src_addr[r]) begin
                    stall_o = 1'b1;
                end
            end
        end
    end

    // pairing
    always_comb begin
        for (int s = 0; s < issue_pkg::ISSUE_WIDTH; s++) begin
            slot_mem[s] = slot_i[s].op == issue_pkg::LW || slot_i[s].op == issue_pkg::SW;
        end
    end

    assign raw_pair = slot_i[0].rd_en && slot_i[0].rd != '0 &&
                      ((slot_i[1].rs1_en && slot_i[1].rs1 == slot_i[0].rd) ||
                       (slot_i[1].rs2_en && slot_i[1].rs2 == slot_i[0].rd));
    assign dual_ok   = slot_i[0].valid && slot_i[1].valid && !(|slot_mem) && !raw_pair;
    assign can_issue = !rst_i && !flush_i && !stall_o;

    always_comb begin
        if (!can_issue) begin
            accept_o = 2'b00;
        end else if (dual_ok) begin
            accept_o = 2'b11;
        end else if (slot_i[0].valid) begin
            accept_o = 2'b01;
        end else if (slot_i[1].valid) begin
            accept_o = 2'b10;
        end else begin
            accept_o = 2'b00;
        end
    end

    always_comb begin
        for (int s = 0; s < issue_pkg::ISSUE_WIDTH; s++) begin
            cand[s].valid = 1'b1;
            cand[s].op    = slot_i[s].op;
            cand[s].rd    = slot_i[s].rd;
            cand[s].rd_en = slot_i[s].rd_en;
            cand[s].src1  = operand[2 * s];
            cand[s].src2  = operand[2 * s + 1];
            cand[s].imm   = slot_i[s].imm;
        end
    end

    // oldest issued op always lands in lane 0
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_op_o <= '0;
        end else begin
            ex_op_o[0] <= accept_o[0] ? cand[0] : (accept_o[1] ? cand[1] : '0);
            ex_op_o[1] <= (accept_o == 2'b11) ? cand[1] : '0;
        end
    end

    a_no_mem_pair: assert property (@(posedge clk) disable iff (rst_i)
        !(accept_o == 2'b11 && slot_mem[0]));

endmodule

`default_nettype wire

/* exec_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_lane #(
    parameter int LANE = 0
) (
    input  wire issue_pkg::issued_op_t op_i,
    output issue_pkg::word_t           result_o,
    fwd_if.source                      fwd
);

    always_comb begin
        case (op_i.op)
            issue_pkg::ADD:  result_o = op_i.src1 + op_i.src2;
            issue_pkg::SUB:  result_o = op_i.src1 - op_i.src2;
            issue_pkg::AND:  result_o = op_i.src1 & op_i.src2;
            issue_pkg::OR:   result_o = op_i.src1 | op_i.src2;
            issue_pkg::XOR:  result_o = op_i.src1 ^ op_i.src2;
            issue_pkg::SLL:  result_o = op_i.src1 << op_i.src2[4:0];
            issue_pkg::SRL:  result_o = op_i.src1 >> op_i.src2[4:0];
            issue_pkg::ADDI: result_o = op_i.src1 + op_i.imm;
            // effective address, store data rides along in src2
            issue_pkg::LW:   result_o = op_i.src1 + op_i.imm;
            issue_pkg::SW:   result_o = op_i.src1 + op_i.imm;
            default:         result_o = '0;
        endcase
    end

    assign fwd.we      = op_i.valid && op_i.rd_en && op_i.rd != '0 &&
                         op_i.op != issue_pkg::SW;
    assign fwd.addr    = op_i.rd;
    assign fwd.data    = result_o;
    assign fwd.is_load = op_i.valid && op_i.op == issue_pkg::LW;

    // memory has a single owner, lane 0
    if (LANE != 0) begin : g_no_mem
        always_comb begin
            a_no_mem_op: assert (!(op_i.valid &&
                (op_i.op == issue_pkg::LW || op_i.op == issue_pkg::SW)))
            else $error("memory op issued to lane %0d", LANE);
        end
    end

endmodule

`default_nettype wire

/* mem_wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
    input  wire                                                     clk,
    input  wire                                                     rst_i,
    input  wire issue_pkg::issued_op_t [issue_pkg::ISSUE_WIDTH-1:0] ex_op_i,
    input  wire issue_pkg::word_t      [issue_pkg::ISSUE_WIDTH-1:0] ex_result_i,
    fwd_if.source                                                   mem0,
    fwd_if.source                                                   mem1,
    fwd_if.source                                                   wb0,
    fwd_if.source                                                   wb1,
    output logic                       [issue_pkg::ISSUE_WIDTH-1:0] wb_en_o,
    output issue_pkg::reg_addr_t       [issue_pkg::ISSUE_WIDTH-1:0] wb_addr_o,
    output issue_pkg::word_t           [issue_pkg::ISSUE_WIDTH-1:0] wb_data_o
);

    issue_pkg::issued_op_t [issue_pkg::ISSUE_WIDTH-1:0] mem_op;
    issue_pkg::word_t      [issue_pkg::ISSUE_WIDTH-1:0] mem_result;
    issue_pkg::word_t      [issue_pkg::ISSUE_WIDTH-1:0] mem_val;
    logic                  [issue_pkg::ISSUE_WIDTH-1:0] mem_we;
    issue_pkg::mem_addr_t  dmem_addr;
    logic                  dmem_store;
    issue_pkg::word_t      dmem [issue_pkg::DMEM_WORDS];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_op <= '0;
        end else begin
            mem_op <= ex_op_i;
        end
    end

    always_ff @(posedge clk) begin
        mem_result <= ex_result_i;
    end

    // byte address, low two bits ignored
    assign dmem_addr  = mem_result[0][2 +: $bits(issue_pkg::mem_addr_t)];
    assign dmem_store = mem_op[0].valid && mem_op[0].op == issue_pkg::SW;

    always_ff @(posedge clk) begin
        if (dmem_store) begin
            dmem[dmem_addr] <= mem_op[0].src2;
        end
    end

    assign mem_val[0] = (mem_op[0].op == issue_pkg::LW) ? dmem[dmem_addr] : mem_result[0];
    assign mem_val[1] = mem_result[1];

    always_comb begin
        for (int l = 0; l < issue_pkg::ISSUE_WIDTH; l++) begin
            mem_we[l] = mem_op[l].valid && mem_op[l].rd_en && mem_op[l].rd != '0 &&
                        mem_op[l].op != issue_pkg::SW;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_en_o <= '0;
        end else begin
            wb_en_o <= mem_we;
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < issue_pkg::ISSUE_WIDTH; l++) begin
            wb_addr_o[l] <= mem_op[l].rd;
        end
        wb_data_o <= mem_val;
    end

    assign mem0.we      = mem_we[0];
    assign mem0.addr    = mem_op[0].rd;
    assign mem0.data    = mem_val[0];
    assign mem0.is_load = 1'b0;
    assign mem1.we      = mem_we[1];
    assign mem1.addr    = mem_op[1].rd;
    assign mem1.data    = mem_val[1];
    assign mem1.is_load = 1'b0;

    assign wb0.we      = wb_en_o[0];
    assign wb0.addr    = wb_addr_o[0];
    assign wb0.data    = wb_data_o[0];
    assign wb0.is_load = 1'b0;
    assign wb1.we      = wb_en_o[1];
    assign wb1.addr    = wb_addr_o[1];
    assign wb1.data    = wb_data_o[1];
    assign wb1.is_load = 1'b0;

    for (genvar l = 0; l < issue_pkg::ISSUE_WIDTH; l++) begin : g_wb_chk
        a_wb_not_r0: assert property (@(posedge clk) disable iff (rst_i)
            wb_en_o[l] |-> wb_addr_o[l] != '0);
    end

endmodule

`default_nettype wire

/* backend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module backend_top (
    input  wire                        clk,
    input  wire                        rst_i,
    input  wire                        flush_i,
    input  wire                        slot0_valid_i,
    input  wire issue_pkg::alu_op_t    slot0_op_i,
    input  wire issue_pkg::reg_addr_t  slot0_rs1_i,
    input  wire                        slot0_rs1_en_i,
    input  wire issue_pkg::reg_addr_t  slot0_rs2_i,
    input  wire                        slot0_rs2_en_i,
    input  wire issue_pkg::reg_addr_t  slot0_rd_i,
    input  wire                        slot0_rd_en_i,
    input  wire issue_pkg::word_t      slot0_imm_i,
    input  wire                        slot1_valid_i,
    input  wire issue_pkg::alu_op_t    slot1_op_i,
    input  wire issue_pkg::reg_addr_t  slot1_rs1_i,
    input  wire                        slot1_rs1_en_i,
    input  wire issue_pkg::reg_addr_t  slot1_rs2_i,
    input  wire                        slot1_rs2_en_i,
    input  wire issue_pkg::reg_addr_t  slot1_rd_i,
    input  wire                        slot1_rd_en_i,
    input  wire issue_pkg::word_t      slot1_imm_i,
    output logic                 [issue_pkg::ISSUE_WIDTH-1:0] accept_o,
    output logic                                              stall_o,
    output logic                 [issue_pkg::ISSUE_WIDTH-1:0] wb_en_o,
    output issue_pkg::reg_addr_t [issue_pkg::ISSUE_WIDTH-1:0] wb_addr_o,
    output issue_pkg::word_t     [issue_pkg::ISSUE_WIDTH-1:0] wb_data_o
);

    issue_pkg::dec_op_t    [issue_pkg::ISSUE_WIDTH-1:0] slot;
    issue_pkg::issued_op_t [issue_pkg::ISSUE_WIDTH-1:0] ex_op;
    issue_pkg::word_t      [issue_pkg::ISSUE_WIDTH-1:0] ex_result;
    issue_pkg::reg_addr_t  [issue_pkg::RF_PORTS-1:0]    rf_addr;
    issue_pkg::word_t      [issue_pkg::RF_PORTS-1:0]    rf_data;

    assign slot[0] = '{valid: slot0_valid_i, op: slot0_op_i,
                       rs1: slot0_rs1_i, rs1_en: slot0_rs1_en_i,
                       rs2: slot0_rs2_i, rs2_en: slot0_rs2_en_i,
                       rd: slot0_rd_i, rd_en: slot0_rd_en_i, imm: slot0_imm_i};
    assign slot[1] = '{valid: slot1_valid_i, op: slot1_op_i,
                       rs1: slot1_rs1_i, rs1_en: slot1_rs1_en_i,
                       rs2: slot1_rs2_i, rs2_en: slot1_rs2_en_i,
                       rd: slot1_rd_i, rd_en: slot1_rd_en_i, imm: slot1_imm_i};

    fwd_if ex0_fwd ();
    fwd_if ex1_fwd ();
    fwd_if mem0_fwd ();
    fwd_if mem1_fwd ();
    fwd_if wb0_fwd ();
    fwd_if wb1_fwd ();

    dispatch u_dispatch (
        .clk       (clk),
        .rst_i     (rst_i),
        .flush_i   (flush_i),
        .slot_i    (slot),
        .rf_addr_o (rf_addr),
        .rf_data_i (rf_data),
        .ex0       (ex0_fwd),
        .ex1       (ex1_fwd),
        .mem0      (mem0_fwd),
        .mem1      (mem1_fwd),
        .wb0       (wb0_fwd),
        .wb1       (wb1_fwd),
        .accept_o  (accept_o),
        .stall_o   (stall_o),
        .ex_op_o   (ex_op)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst_i   (rst_i),
        .raddr_i (rf_addr),
        .rdata_o (rf_data),
        .we_i    (wb_en_o),
        .waddr_i (wb_addr_o),
        .wdata_i (wb_data_o)
    );

    exec_lane #(.LANE(0)) u_lane0 (
        .op_i     (ex_op[0]),
        .result_o (ex_result[0]),
        .fwd      (ex0_fwd)
    );

    exec_lane #(.LANE(1)) u_lane1 (
        .op_i     (ex_op[1]),
        .result_o (ex_result[1]),
        .fwd      (ex1_fwd)
    );

    mem_wb_stage u_mem_wb (
        .clk         (clk),
        .rst_i       (rst_i),
        .ex_op_i     (ex_op),
        .ex_result_i (ex_result),
        .mem0        (mem0_fwd),
        .mem1        (mem1_fwd),
        .wb0         (wb0_fwd),
        .wb1         (wb1_fwd),
        .wb_en_o     (wb_en_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o)
    );

endmodule

`default_nettype wire

/* tb_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_backend;

    localparam int RESET_CYCLES = 8;
    localparam int NUM_TESTS    = 6;
    localparam int RANDOM_OPS   = 200;

    logic                                            clk;
    logic                                            rst_i;
    logic                                            flush_i;
    issue_pkg::dec_op_t                              slot0_d;
    issue_pkg::dec_op_t                              slot1_d;
    logic                 [issue_pkg::ISSUE_WIDTH-1:0] accept;
    logic                                            stall;
    logic                 [issue_pkg::ISSUE_WIDTH-1:0] wb_en;
    issue_pkg::reg_addr_t [issue_pkg::ISSUE_WIDTH-1:0] wb_addr;
    issue_pkg::word_t     [issue_pkg::ISSUE_WIDTH-1:0] wb_data;

    issue_pkg::dec_op_t   all_prog [$];
    issue_pkg::dec_op_t   prog [$];
    issue_pkg::reg_addr_t exp_addr [$];
    issue_pkg::word_t     exp_data [$];
    issue_pkg::word_t     model_regs [32];
    issue_pkg::word_t     model_mem [issue_pkg::DMEM_WORDS];
    int                   test_end [NUM_TESTS];
    string                test_name [NUM_TESTS];
    issue_pkg::reg_addr_t e_addr;
    issue_pkg::word_t     e_data;
    int                   seed;
    int                   errors;
    int                   tests_ok;
    int                   dual_cnt;
    int                   stall_cnt;
    int                   flush_cnt;
    int                   cycles;
    int                   cycle_limit;

    backend_top dut (
        .clk            (clk),
        .rst_i          (rst_i),
        .flush_i        (flush_i),
        .slot0_valid_i  (slot0_d.valid),
        .slot0_op_i     (slot0_d.op),
        .slot0_rs1_i    (slot0_d.rs1),
        .slot0_rs1_en_i (slot0_d.rs1_en),
        .slot0_rs2_i    (slot0_d.rs2),
        .slot0_rs2_en_i (slot0_d.rs2_en),
        .slot0_rd_i     (slot0_d.rd),
        .slot0_rd_en_i  (slot0_d.rd_en),
        .slot0_imm_i    (slot0_d.imm),
        .slot1_valid_i  (slot1_d.valid),
        .slot1_op_i     (slot1_d.op),
        .slot1_rs1_i    (slot1_d.rs1),
        .slot1_rs1_en_i (slot1_d.rs1_en),
        .slot1_rs2_i    (slot1_d.rs2),
        .slot1_rs2_en_i (slot1_d.rs2_en),
        .slot1_rd_i     (slot1_d.rd),
        .slot1_rd_en_i  (slot1_d.rd_en),
        .slot1_imm_i    (slot1_d.imm),
        .accept_o       (accept),
        .stall_o        (stall),
        .wb_en_o        (wb_en),
        .wb_addr_o      (wb_addr),
        .wb_data_o      (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic issue_pkg::dec_op_t make_op(issue_pkg::alu_op_t op, int rd, int rs1,
                                                   int rs2, int imm);
        issue_pkg::dec_op_t d;
        d.valid  = 1'b1;
        d.op     = op;
        d.rs1    = rs1[4:0];
        d.rs1_en = 1'b1;
        d.rs2    = rs2[4:0];
        d.rs2_en = !(op == issue_pkg::ADDI || op == issue_pkg::LW);
        d.rd     = rd[4:0];
        d.rd_en  = op != issue_pkg::SW;
        d.imm    = imm;
        return d;
    endfunction

    // expected ALU output, address for loads and stores
    function automatic issue_pkg::word_t alu_ref(issue_pkg::alu_op_t op, issue_pkg::word_t a,
                                                 issue_pkg::word_t b, issue_pkg::word_t imm);
        case (op)
            issue_pkg::ADD:  return a + b;
            issue_pkg::SUB:  return a - b;
            issue_pkg::AND:  return a & b;
            issue_pkg::OR:   return a | b;
            issue_pkg::XOR:  return a ^ b;
            issue_pkg::SLL:  return a << b[4:0];
            issue_pkg::SRL:  return a >> b[4:0];
            default:         return a + imm;
        endcase
    endfunction

    // in-order model of one program segment
    function automatic void predict(int first, int last);
        issue_pkg::dec_op_t   d;
        issue_pkg::word_t     a;
        issue_pkg::word_t     b;
        issue_pkg::word_t     res;
        issue_pkg::mem_addr_t idx;
        for (int i = first; i < last; i++) begin
            d = all_prog[i];
            a = !d.rs1_en ? d.imm : (d.rs1 == '0 ? '0 : model_regs[d.rs1]);
            b = !d.rs2_en ? d.imm : (d.rs2 == '0 ? '0 : model_regs[d.rs2]);
            res = alu_ref(d.op, a, b, d.imm);
            idx = res[7:2];
            if (d.op == issue_pkg::SW) begin
                model_mem[idx] = b;
            end else if (d.op == issue_pkg::LW) begin
                res = model_mem[idx];
            end
            if (d.op != issue_pkg::SW && d.rd_en && d.rd != '0) begin
                model_regs[d.rd] = res;
                exp_addr.push_back(d.rd);
                exp_data.push_back(res);
            end
        end
    endfunction

    task automatic build_random();
        issue_pkg::dec_op_t   d;
        issue_pkg::alu_op_t   op;
        issue_pkg::mem_addr_t idx;
        logic [63:0]          written;
        int                   r;
        written = '0;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r = $unsigned($random(seed)) % 10;
            op = issue_pkg::alu_op_t'(r[3:0]);
            idx = issue_pkg::mem_addr_t'($unsigned($random(seed)) % 64);
            // never load a word that was not stored
            if (op == issue_pkg::LW && !written[idx]) begin
                op = issue_pkg::SW;
            end
            if (op == issue_pkg::LW || op == issue_pkg::SW) begin
                d = make_op(op, $unsigned($random(seed)) % 32, 0,
                            $unsigned($random(seed)) % 32, 4 * int'(idx));
                if (op == issue_pkg::SW) begin
                    written[idx] = 1'b1;
                end
            end else begin
                d = make_op(op, $unsigned($random(seed)) % 32, $unsigned($random(seed)) % 32,
                            $unsigned($random(seed)) % 32, $random(seed));
                if (($unsigned($random(seed)) % 8) == 0) begin
                    d.rs1_en = 1'b0;
                end
            end
            all_prog.push_back(d);
        end
    endtask

    task automatic build_programs();
        test_name[0] = "independent pairs";
        all_prog.push_back(make_op(issue_pkg::ADDI, 1, 0, 0, 5));
        all_prog.push_back(make_op(issue_pkg::ADDI, 2, 0, 0, 7));
        all_prog.push_back(make_op(issue_pkg::ADD, 3, 1, 2, 0));
        all_prog.push_back(make_op(issue_pkg::XOR, 4, 1, 2, 0));
        all_prog.push_back(make_op(issue_pkg::SUB, 5, 3, 4, 0));
        all_prog.push_back(make_op(issue_pkg::SLL, 6, 1, 2, 0));
        test_end[0] = all_prog.size();
        test_name[1] = "single issue";
        all_prog.push_back(make_op(issue_pkg::ADDI, 7, 0, 0, 100));
        all_prog.push_back(make_op(issue_pkg::ADD, 8, 7, 7, 0));
        all_prog.push_back(make_op(issue_pkg::SW, 0, 0, 8, 16));
        all_prog.push_back(make_op(issue_pkg::LW, 9, 0, 0, 16));
        all_prog.push_back(make_op(issue_pkg::ADDI, 10, 8, 0, 1));
        all_prog.push_back(make_op(issue_pkg::SUB, 11, 10, 8, 0));
        test_end[1] = all_prog.size();
        test_name[2] = "forwarding and r0";
        all_prog.push_back(make_op(issue_pkg::ADDI, 12, 0, 0, 3));
        all_prog.push_back(make_op(issue_pkg::ADDI, 13, 12, 0, 4));
        all_prog.push_back(make_op(issue_pkg::ADD, 14, 12, 13, 0));
        all_prog.push_back(make_op(issue_pkg::SUB, 15, 14, 12, 0));
        all_prog.push_back(make_op(issue_pkg::ADDI, 0, 12, 0, 9));
        all_prog.push_back(make_op(issue_pkg::ADDI, 18, 0, 0, 1));
        all_prog.push_back(make_op(issue_pkg::ADDI, 18, 0, 0, 2));
        all_prog.push_back(make_op(issue_pkg::OR, 16, 0, 15, 0));
        all_prog.push_back(make_op(issue_pkg::ADD, 19, 18, 18, 0));
        all_prog.push_back(make_op(issue_pkg::XOR, 17, 16, 0, 0));
        test_end[2] = all_prog.size();
        test_name[3] = "load use";
        all_prog.push_back(make_op(issue_pkg::ADDI, 20, 0, 0, 'h55));
        all_prog.push_back(make_op(issue_pkg::SW, 0, 0, 20, 32));
        all_prog.push_back(make_op(issue_pkg::LW, 21, 0, 0, 32));
        all_prog.push_back(make_op(issue_pkg::ADD, 22, 21, 20, 0));
        test_end[3] = all_prog.size();
        test_name[4] = "store then load";
        all_prog.push_back(make_op(issue_pkg::ADDI, 23, 0, 0, -1234));
        all_prog.push_back(make_op(issue_pkg::ADDI, 24, 0, 0, 40));
        all_prog.push_back(make_op(issue_pkg::SW, 0, 24, 23, 8));
        all_prog.push_back(make_op(issue_pkg::LW, 25, 24, 0, 8));
        all_prog.push_back(make_op(issue_pkg::LW, 26, 0, 0, 48));
        all_prog.push_back(make_op(issue_pkg::ADD, 27, 25, 26, 0));
        test_end[4] = all_prog.size();
        test_name[5] = "random with flush";
        build_random();
        test_end[5] = all_prog.size();
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("ERROR t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic run_test(input int t);
        int first;
        int errs_before;
        first = (t == 0) ? 0 : test_end[t-1];
        errs_before = errors;
        dual_cnt = 0;
        stall_cnt = 0;
        flush_cnt = 0;
        predict(first, test_end[t]);
        for (int i = first; i < test_end[t]; i++) begin
            prog.push_back(all_prog[i]);
        end
        while (prog.size() > 0) begin
            @(negedge clk);
            slot0_d = prog[0];
            slot1_d = (prog.size() > 1) ? prog[1] : '0;
            flush_i = (t == NUM_TESTS - 1) && (($unsigned($random(seed)) % 8) == 0);
            #1;
            if (flush_i) begin
                flush_cnt++;
                assert (accept == 2'b00) else begin
                    $display("ERROR t=%0t accept_o expected 00 actual %b", $time, accept);
                    errors++;
                end
            end
            dual_cnt += (accept == 2'b11);
            stall_cnt += stall;
            repeat ($countones(accept)) void'(prog.pop_front());
        end
        @(negedge clk);
        slot0_d = '0;
        slot1_d = '0;
        flush_i = 1'b0;
        while (exp_addr.size() > 0) begin
            @(negedge clk);
            #2;
        end
        case (t)
            0: check_count("dual_issue_cycles", 3, dual_cnt);
            1: check_count("dual_issue_cycles", 0, dual_cnt);
            3: check_count("stall_o_cycles", 1, stall_cnt);
            5: assert (flush_cnt > 0) else begin
                $display("no flush strobe was applied during the random program");
                errors++;
            end
            default: ;
        endcase
        if (errors == errs_before) begin
            tests_ok++;
            $display("[%0d] %s: ok", t + 1, test_name[t]);
        end else begin
            $display("[%0d] %s: %0d errors", t + 1, test_name[t], errors - errs_before);
        end
    endtask

    // wb outputs are registered, stable at the falling edge
    always @(negedge clk) begin
        if (!rst_i) begin
            for (int l = 0; l < issue_pkg::ISSUE_WIDTH; l++) begin
                if (wb_en[l]) begin
                    assert (exp_addr.size() > 0) else begin
                        $display("lane %0d retired a write at %0t with none expected", l, $time);
                        errors++;
                    end
                    if (exp_addr.size() > 0) begin
                        e_addr = exp_addr.pop_front();
                        e_data = exp_data.pop_front();
                        assert (wb_addr[l] == e_addr) else begin
                            $display("ERROR t=%0t wb_addr_o[%0d] expected %0d actual %0d",
                                     $time, l, e_addr, wb_addr[l]);
                            errors++;
                        end
                        assert (wb_data[l] == e_data) else begin
                            $display("ERROR t=%0t wb_data_o[%0d] expected %h actual %h",
                                     $time, l, e_data, wb_data[l]);
                            errors++;
                        end
                    end
                end
            end
        end
    end

    initial begin
        cycles = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: %0d cycles passed and the pipeline did not drain", cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        seed = 60;
        errors = 0;
        tests_ok = 0;
        rst_i = 1'b1;
        flush_i = 1'b0;
        slot0_d = '0;
        slot1_d = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        build_programs();
        cycle_limit = 4 * all_prog.size() + 50;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("counts: %0d tests, %0d ok, %0d errors", NUM_TESTS, tests_ok, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
issue_pkg.sv
fwd_if.sv
regfile.sv
dispatch.sv
exec_lane.sv
mem_wb_stage.sv
backend_top.sv
tb_backend.sv

/* run.sh */
#!/bin/sh
# build and run the backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_backend -f all.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_backend)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1
